/* rtl/nx_msg_pkg.sv */
// Mesh message format, command encoding and address widths
package nx_msg_pkg;

    // Mesh coordinate widths
    localparam int unsigned NX_ROW_W  = 4;
    localparam int unsigned NX_COL_W  = 4;

    // Register address width bounds the register count of a node
    localparam int unsigned NX_ADDR_W = 4;

    // Payload carried by every message
    localparam int unsigned NX_DATA_W = 16;

    // Message commands
    // Encoding 2'd3 is unused and is treated as a stray message
    typedef enum logic [1:0] {
        NX_CMD_WRITE    = 2'd0,
        NX_CMD_READ     = 2'd1,
        NX_CMD_RESPONSE = 2'd2
    } nx_command_t;

    // Single-flit message of 38 bits in total
    // Target first so the routing bits sit at the top of the word
    typedef struct packed {
        // Destination node
        logic [NX_ROW_W-1:0]  tgt_row;
        logic [NX_COL_W-1:0]  tgt_col;
        // Originating node used as the return address of a read
        logic [NX_ROW_W-1:0]  src_row;
        logic [NX_COL_W-1:0]  src_col;
        // Operation requested at the destination
        nx_command_t          command;
        // Register address and payload
        logic [NX_ADDR_W-1:0] addr;
        logic [NX_DATA_W-1:0] data;
    } nx_message_t;

endpackage

/* rtl/nx_node_pkg.sv */
// Node-internal types for routing, register access and egress arbitration
package nx_node_pkg;

    // Where the decoder sends the message at the FIFO head
    typedef enum logic [1:0] {
        ROUTE_FORWARD = 2'd0,  // target is another node
        ROUTE_WRITE   = 2'd1,  // local register write
        ROUTE_READ    = 2'd2,  // local register read
        ROUTE_DROP    = 2'd3   // response or unknown command for this node
    } nx_route_t;

    // 29-bit request from the decoder to the register file
    typedef struct packed {
        // High for a write, low for a read
        logic                             write;
        logic [nx_msg_pkg::NX_ADDR_W-1:0] addr;
        logic [nx_msg_pkg::NX_DATA_W-1:0] data;
        // Source of the request where the response goes back
        logic [nx_msg_pkg::NX_ROW_W-1:0]  ret_row;
        logic [nx_msg_pkg::NX_COL_W-1:0]  ret_col;
    } nx_reg_req_t;

    // Last source granted into the egress register
    typedef enum logic {
        EGRESS_FORWARD  = 1'b0,
        EGRESS_RESPONSE = 1'b1
    } nx_egress_src_t;

endpackage

/* rtl/nx_fifo.sv */
// Synchronous circular-buffer FIFO with level, empty and full status
`timescale 1ns/10ps

module nx_fifo #(
      parameter int unsigned DEPTH    = 2      // Number of entries
    , parameter int unsigned WIDTH    = 32     // Bits per entry
    , parameter int unsigned FULL_LVL = DEPTH  // Level that raises full_o
) (
      input  logic                             clk_i
    , input  logic                             rst_i
    // Write side
    , input  logic [WIDTH-1:0]                 wr_data_i
    , input  logic                             wr_push_i
    // Read side
    , output logic [WIDTH-1:0]                 rd_data_o
    , input  logic                             rd_pop_i
    // Status
    , output logic [$clog2(DEPTH + 1)-1:0]     level_o
    , output logic                             empty_o
    , output logic                             full_o
);

    // Pointer needs at least one bit even for a single entry
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // Level counts 0..DEPTH inclusive
    localparam int unsigned LVL_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [LVL_W-1:0] level_q;
    logic             truly_full;
    logic             push_ok;
    logic             pop_ok;

    assign rd_data_o  = mem_q[rd_ptr_q];
    assign level_o    = level_q;
    assign empty_o    = (level_q == '0);
    assign full_o     = (level_q >= LVL_W'(FULL_LVL));
    assign truly_full = (level_q == LVL_W'(DEPTH));

    // Push goes in when there is room, or when the head leaves this cycle
    assign push_ok = wr_push_i && (!truly_full || rd_pop_i);
    // Pop on an empty FIFO is ignored
    assign pop_ok  = rd_pop_i && !empty_o;

    // Pointers and occupancy
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            // Explicit wrap as DEPTH need not be a power of two
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            case ({push_ok, pop_ok})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    // Occupancy stays within the storage over any push/pop history
    a_level_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        level_q <= LVL_W'(DEPTH))
        else $error("nx_fifo: level exceeds depth");

    // Consumer must look at empty_o before popping
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        rd_pop_i |-> !empty_o)
        else $error("nx_fifo: pop requested while empty");

endmodule

/* rtl/nx_msg_decoder.sv */
// Classifies the inbound FIFO head and pops it once its destination can accept it
`timescale 1ns/10ps

module nx_msg_decoder #(
      parameter logic [nx_msg_pkg::NX_ROW_W-1:0] ROW = '0
    , parameter logic [nx_msg_pkg::NX_COL_W-1:0] COL = '0
) (
      input  logic                     clk_i
    , input  logic                     rst_i
    // FIFO head
    , input  nx_msg_pkg::nx_message_t  head_i
    , input  logic                     empty_i
    , output logic                     pop_o
    // Forward path towards the egress arbiter
    , output logic                     fwd_req_o
    , output nx_msg_pkg::nx_message_t  fwd_msg_o
    , input  logic                     fwd_ready_i
    // Register file path
    , output logic                     reg_req_o
    , output nx_node_pkg::nx_reg_req_t reg_op_o
    , input  logic                     resp_pending_i
    // Stray response indication
    , output logic                     dropped_o
);

    nx_node_pkg::nx_route_t route;
    logic                   is_local;
    logic                   dest_ready;
    logic                   dropped_q;

    // Message belongs here when both coordinates match
    assign is_local = (head_i.tgt_row == ROW) && (head_i.tgt_col == COL);

    // Route selection from target and command
    always_comb begin
        if (!is_local) begin
            route = nx_node_pkg::ROUTE_FORWARD;
        end else begin
            case (head_i.command)
                nx_msg_pkg::NX_CMD_WRITE: route = nx_node_pkg::ROUTE_WRITE;
                nx_msg_pkg::NX_CMD_READ:  route = nx_node_pkg::ROUTE_READ;
                // Responses have no local consumer
                default:                  route = nx_node_pkg::ROUTE_DROP;
            endcase
        end
    end

    // Readiness of the chosen destination
    always_comb begin
        case (route)
            nx_node_pkg::ROUTE_FORWARD: dest_ready = fwd_ready_i;
            // Only one response can be held, so a read waits for it to leave
            nx_node_pkg::ROUTE_READ:    dest_ready = !resp_pending_i;
            // Writes and drops always complete at once
            default:                    dest_ready = 1'b1;
        endcase
    end

    assign pop_o = !empty_i && dest_ready;

    // Forward request is independent of readiness
    assign fwd_req_o = !empty_i && (route == nx_node_pkg::ROUTE_FORWARD);
    assign fwd_msg_o = head_i;

    // Register request fires only on the popping cycle
    assign reg_req_o = pop_o && ((route == nx_node_pkg::ROUTE_WRITE) ||
                                 (route == nx_node_pkg::ROUTE_READ));

    always_comb begin
        reg_op_o.write   = (route == nx_node_pkg::ROUTE_WRITE);
        reg_op_o.addr    = head_i.addr;
        reg_op_o.data    = head_i.data;
        // Reply goes back to whoever asked
        reg_op_o.ret_row = head_i.src_row;
        reg_op_o.ret_col = head_i.src_col;
    end

    // One-cycle pulse after each dropped message
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            dropped_q <= 1'b0;
        end else begin
            dropped_q <= pop_o && (route == nx_node_pkg::ROUTE_DROP);
        end
    end

    assign dropped_o = dropped_q;

    // A waiting head stays in place and unchanged until it is popped
    a_head_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (!empty_i && !pop_o) |=> (!empty_i && $stable(head_i)))
        else $error("nx_msg_decoder: FIFO head changed without a pop");

endmodule

/* rtl/nx_node_regs.sv */
// Local register file executing writes and building read responses
`timescale 1ns/10ps

module nx_node_regs #(
      parameter logic [nx_msg_pkg::NX_ROW_W-1:0] ROW       = '0
    , parameter logic [nx_msg_pkg::NX_COL_W-1:0] COL       = '0
    , parameter int unsigned                     REG_COUNT = 16
) (
      input  logic                     clk_i
    , input  logic                     rst_i
    // Request from the decoder
    , input  logic                     req_i
    , input  nx_node_pkg::nx_reg_req_t req_op_i
    // Response towards the egress arbiter
    , output logic                     resp_pending_o
    , output nx_msg_pkg::nx_message_t  resp_msg_o
    , input  logic                     resp_grant_i
);

    logic [nx_msg_pkg::NX_DATA_W-1:0] regs_q [REG_COUNT];
    logic                             resp_pending_q;
    nx_msg_pkg::nx_message_t          resp_msg_q;
    logic                             addr_ok;
    logic [nx_msg_pkg::NX_DATA_W-1:0] rd_data;

    // Addresses beyond the array are ignored and read as zero
    assign addr_ok = (32'(req_op_i.addr) < REG_COUNT);
    assign rd_data = addr_ok ? regs_q[req_op_i.addr] : '0;

    // Register array cleared by reset
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < int'(REG_COUNT); i++) begin
                regs_q[i] <= '0;
            end
        end else if (req_i && req_op_i.write && addr_ok) begin
            regs_q[req_op_i.addr] <= req_op_i.data;
        end
    end

    // Pending flag set by a read and cleared once the arbiter takes it
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            resp_pending_q <= 1'b0;
        end else if (req_i && !req_op_i.write) begin
            resp_pending_q <= 1'b1;
        end else if (resp_grant_i) begin
            resp_pending_q <= 1'b0;
        end
    end

    // Response payload captured on the read
    always_ff @(posedge clk_i) begin
        if (req_i && !req_op_i.write) begin
            resp_msg_q.tgt_row <= req_op_i.ret_row;
            resp_msg_q.tgt_col <= req_op_i.ret_col;
            resp_msg_q.src_row <= ROW;
            resp_msg_q.src_col <= COL;
            resp_msg_q.command <= nx_msg_pkg::NX_CMD_RESPONSE;
            resp_msg_q.addr    <= req_op_i.addr;
            resp_msg_q.data    <= rd_data;
        end
    end

    assign resp_pending_o = resp_pending_q;
    assign resp_msg_o     = resp_msg_q;

    // Decoder holds reads back while the single response slot is busy
    a_no_read_overrun: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_i && !req_op_i.write) |-> !resp_pending_q)
        else $error("nx_node_regs: read arrived with a response pending");

endmodule

/* rtl/nx_egress_arb.sv */
// Round-robin merge of forwarded and response messages into a stallable output register
`timescale 1ns/10ps

module nx_egress_arb (
      input  logic                    clk_i
    , input  logic                    rst_i
    // Forwarded traffic from the decoder
    , input  logic                    fwd_req_i
    , input  nx_msg_pkg::nx_message_t fwd_msg_i
    , output logic                    fwd_ready_o
    // Read responses from the register file
    , input  logic                    resp_pending_i
    , input  nx_msg_pkg::nx_message_t resp_msg_i
    , output logic                    resp_grant_o
    // Outbound port
    , output logic                    out_valid_o
    , output nx_msg_pkg::nx_message_t out_msg_o
    , input  logic                    out_stall_i
);

    nx_node_pkg::nx_egress_src_t last_q;
    logic                        out_valid_q;
    nx_msg_pkg::nx_message_t     out_msg_q;
    logic                        can_load;
    logic                        fwd_take;

    // Output slot is free when empty or delivered this cycle
    assign can_load = !out_valid_q || !out_stall_i;

    // Response wins when alone, or when forward went last
    assign resp_grant_o = can_load && resp_pending_i &&
                          (!fwd_req_i || (last_q == nx_node_pkg::EGRESS_FORWARD));

    assign fwd_ready_o = can_load && !resp_grant_o;
    assign fwd_take    = fwd_req_i && fwd_ready_o;

    // Valid flag and last-granted source
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
            last_q      <= nx_node_pkg::EGRESS_FORWARD;
        end else if (can_load) begin
            out_valid_q <= resp_grant_o || fwd_take;
            if (resp_grant_o) begin
                last_q <= nx_node_pkg::EGRESS_RESPONSE;
            end else if (fwd_take) begin
                last_q <= nx_node_pkg::EGRESS_FORWARD;
            end
        end
    end

    // Output payload held whenever nothing is granted
    always_ff @(posedge clk_i) begin
        if (resp_grant_o) begin
            out_msg_q <= resp_msg_i;
        end else if (fwd_take) begin
            out_msg_q <= fwd_msg_i;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_msg_o   = out_msg_q;

    // Stalled message stays put until delivered
    a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && out_stall_i) |=> (out_valid_o && $stable(out_msg_o)))
        else $error("nx_egress_arb: output changed while stalled");

endmodule

/* rtl/nx_node.sv */
// Mesh node top level with inbound FIFO, decoder, register file and egress arbiter
`timescale 1ns/10ps

module nx_node #(
      parameter logic [nx_msg_pkg::NX_ROW_W-1:0] ROW       = '0
    , parameter logic [nx_msg_pkg::NX_COL_W-1:0] COL       = '0
    , parameter int unsigned                     IN_DEPTH  = 4
    , parameter int unsigned                     REG_COUNT = 16
) (
      input  logic                    clk_i
    , input  logic                    rst_i
    // Inbound port with plain push strobe and full level
    , input  logic                    in_push_i
    , input  nx_msg_pkg::nx_message_t in_msg_i
    , output logic                    in_full_o
    // Outbound port with valid and stall
    , output logic                    out_valid_o
    , output nx_msg_pkg::nx_message_t out_msg_o
    , input  logic                    out_stall_i
    // Stray response seen
    , output logic                    dropped_o
);

    // FIFO head towards the decoder
    nx_msg_pkg::nx_message_t  fifo_head;
    logic                     fifo_empty;
    logic                     fifo_pop;
    // Forward path
    logic                     fwd_req;
    nx_msg_pkg::nx_message_t  fwd_msg;
    logic                     fwd_ready;
    // Register path
    logic                     reg_req;
    nx_node_pkg::nx_reg_req_t reg_op;
    // Response path
    logic                     resp_pending;
    nx_msg_pkg::nx_message_t  resp_msg;
    logic                     resp_grant;

    // Inbound buffer that is full only when every entry is taken
    nx_fifo #(
          .DEPTH    (IN_DEPTH)
        , .WIDTH    ($bits(nx_msg_pkg::nx_message_t))
        , .FULL_LVL (IN_DEPTH)
    ) fifo_i (
          .clk_i     (clk_i)
        , .rst_i     (rst_i)
        , .wr_data_i (in_msg_i)
        , .wr_push_i (in_push_i)
        , .rd_data_o (fifo_head)
        , .rd_pop_i  (fifo_pop)
        , .level_o   ()
        , .empty_o   (fifo_empty)
        , .full_o    (in_full_o)
    );

    nx_msg_decoder #(
          .ROW (ROW)
        , .COL (COL)
    ) decoder_i (
          .clk_i          (clk_i)
        , .rst_i          (rst_i)
        , .head_i         (fifo_head)
        , .empty_i        (fifo_empty)
        , .pop_o          (fifo_pop)
        , .fwd_req_o      (fwd_req)
        , .fwd_msg_o      (fwd_msg)
        , .fwd_ready_i    (fwd_ready)
        , .reg_req_o      (reg_req)
        , .reg_op_o       (reg_op)
        , .resp_pending_i (resp_pending)
        , .dropped_o      (dropped_o)
    );

    nx_node_regs #(
          .ROW       (ROW)
        , .COL       (COL)
        , .REG_COUNT (REG_COUNT)
    ) regs_i (
          .clk_i          (clk_i)
        , .rst_i          (rst_i)
        , .req_i          (reg_req)
        , .req_op_i       (reg_op)
        , .resp_pending_o (resp_pending)
        , .resp_msg_o     (resp_msg)
        , .resp_grant_i   (resp_grant)
    );

    // Single outbound port shared by forwards and responses
    nx_egress_arb egress_i (
          .clk_i          (clk_i)
        , .rst_i          (rst_i)
        , .fwd_req_i      (fwd_req)
        , .fwd_msg_i      (fwd_msg)
        , .fwd_ready_o    (fwd_ready)
        , .resp_pending_i (resp_pending)
        , .resp_msg_i     (resp_msg)
        , .resp_grant_o   (resp_grant)
        , .out_valid_o    (out_valid_o)
        , .out_msg_o      (out_msg_o)
        , .out_stall_i    (out_stall_i)
    );

endmodule

/* tb/tb_nx_node.sv */
// Mesh node testbench with clock, reset, stimulus, reference model and checking assertions
`timescale 1ns/10ps

module tb_nx_node;

    // Node position and sizing of the DUT
    localparam logic [nx_msg_pkg::NX_ROW_W-1:0] NODE_ROW = 4'd2;
    localparam logic [nx_msg_pkg::NX_COL_W-1:0] NODE_COL = 4'd3;
    localparam int unsigned IN_DEPTH   = 4;
    localparam int unsigned REG_COUNT  = 16;
    // Cycles any single wait may take
    localparam int unsigned WAIT_LIMIT = 2000;
    localparam int unsigned MSG_W      = $bits(nx_msg_pkg::nx_message_t);

    logic                    clk_i       = 1'b0;
    logic                    rst_i       = 1'b1;
    logic                    in_push_i   = 1'b0;
    nx_msg_pkg::nx_message_t in_msg_i    = '0;
    logic                    in_full_o;
    logic                    out_valid_o;
    nx_msg_pkg::nx_message_t out_msg_o;
    logic                    out_stall_i = 1'b0;
    logic                    dropped_o;

    // Stall pattern held high or random per cycle
    logic stall_hold   = 1'b0;
    logic stall_random = 1'b0;

    // Reference model
    // Shadow copy of the node registers
    logic [nx_msg_pkg::NX_DATA_W-1:0] shadow_regs [REG_COUNT];
    // Expected outbound messages in one ring per source
    nx_msg_pkg::nx_message_t fwd_mem  [256];
    nx_msg_pkg::nx_message_t resp_mem [256];
    logic [7:0]              fwd_wr  = '0;
    logic [7:0]              fwd_rd  = '0;
    logic [7:0]              resp_wr = '0;
    logic [7:0]              resp_rd = '0;
    int unsigned             drops_expected = 0;
    int unsigned             drops_seen     = 0;

    nx_msg_pkg::nx_message_t exp_fwd;
    nx_msg_pkg::nx_message_t exp_resp;
    nx_msg_pkg::nx_message_t prev_out_msg;
    logic                    delivered;
    logic                    is_resp;
    logic                    local_target;

    nx_node #(
          .ROW       (NODE_ROW)
        , .COL       (NODE_COL)
        , .IN_DEPTH  (IN_DEPTH)
        , .REG_COUNT (REG_COUNT)
    ) dut_i (
          .clk_i       (clk_i)
        , .rst_i       (rst_i)
        , .in_push_i   (in_push_i)
        , .in_msg_i    (in_msg_i)
        , .in_full_o   (in_full_o)
        , .out_valid_o (out_valid_o)
        , .out_msg_o   (out_msg_o)
        , .out_stall_i (out_stall_i)
        , .dropped_o   (dropped_o)
    );

    // 10 ns clock
    always #5 clk_i = ~clk_i;

    // Downstream back-pressure of roughly one cycle in three when random
    always @(posedge clk_i) begin
        out_stall_i <= stall_hold || (stall_random && ($urandom_range(0, 2) == 0));
    end

    // Delivery happens on any edge with valid high and stall low
    assign delivered    = out_valid_o && !out_stall_i;
    // Responses built here carry this node as source
    assign is_resp      = (out_msg_o.command == nx_msg_pkg::NX_CMD_RESPONSE) &&
                          (out_msg_o.src_row == NODE_ROW) && (out_msg_o.src_col == NODE_COL);
    assign local_target = (out_msg_o.tgt_row == NODE_ROW) && (out_msg_o.tgt_col == NODE_COL);
    assign exp_fwd      = fwd_mem[fwd_rd];
    assign exp_resp     = resp_mem[resp_rd];

    // Retire the expected head of whichever source just left
    always @(posedge clk_i) begin
        prev_out_msg <= out_msg_o;
        if (!rst_i && delivered) begin
            if (is_resp) begin
                resp_rd <= resp_rd + 1'b1;
            end else begin
                fwd_rd <= fwd_rd + 1'b1;
            end
        end
        if (!rst_i && dropped_o) begin
            drops_seen <= drops_seen + 1;
        end
    end

    task automatic report_mismatch(input string name, input logic [MSG_W-1:0] expected,
                                   input logic [MSG_W-1:0] actual);
        $display("Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("=== FAIL ===");
        $fatal(1, "stopped on mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("Failure at %0t: %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "stopped on failure");
    endtask

    // Forwards in push order
    a_fwd_expected: assert property (@(posedge clk_i) disable iff (rst_i)
        (delivered && !is_resp) |-> (fwd_rd != fwd_wr))
        else abort_run("a forwarded message left the node with none outstanding");
    a_fwd_match: assert property (@(posedge clk_i) disable iff (rst_i)
        (delivered && !is_resp && (fwd_rd != fwd_wr)) |-> (out_msg_o == exp_fwd))
        else report_mismatch("out_msg_o", $sampled(exp_fwd), $sampled(out_msg_o));

    // Responses in read order
    a_resp_expected: assert property (@(posedge clk_i) disable iff (rst_i)
        (delivered && is_resp) |-> (resp_rd != resp_wr))
        else abort_run("a response left the node with no read outstanding");
    a_resp_match: assert property (@(posedge clk_i) disable iff (rst_i)
        (delivered && is_resp && (resp_rd != resp_wr)) |-> (out_msg_o == exp_resp))
        else report_mismatch("out_msg_o", $sampled(exp_resp), $sampled(out_msg_o));

    // Nothing addressed here may leave, stray responses included
    a_no_local_target: assert property (@(posedge clk_i) disable iff (rst_i)
        delivered |-> !local_target)
        else abort_run("a message addressed to this node left on the outbound port");

    // Held output under stall
    a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && out_stall_i) |=> (out_msg_o == prev_out_msg))
        else report_mismatch("out_msg_o", $sampled(prev_out_msg), $sampled(out_msg_o));

    // Drop flag is a single-cycle pulse per stray response
    a_drop_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        dropped_o |=> !dropped_o)
        else abort_run("dropped_o stayed high for more than one cycle");
    a_drop_expected: assert property (@(posedge clk_i) disable iff (rst_i)
        dropped_o |-> (drops_seen < drops_expected))
        else abort_run("dropped_o rose with no stray response pushed");

    function automatic nx_msg_pkg::nx_message_t make_msg(
        input logic [3:0]              tgt_row,
        input logic [3:0]              tgt_col,
        input logic [3:0]              src_row,
        input logic [3:0]              src_col,
        input nx_msg_pkg::nx_command_t command,
        input logic [3:0]              addr,
        input logic [15:0]             data
    );
        nx_msg_pkg::nx_message_t m;
        m.tgt_row = tgt_row;
        m.tgt_col = tgt_col;
        m.src_row = src_row;
        m.src_col = src_col;
        m.command = command;
        m.addr    = addr;
        m.data    = data;
        return m;
    endfunction

    // Random message for another node that never looks like a local response
    function automatic nx_msg_pkg::nx_message_t random_forward();
        nx_msg_pkg::nx_message_t m;
        m.tgt_row = 4'($urandom_range(0, 15));
        m.tgt_col = 4'($urandom_range(0, 15));
        m.src_row = 4'($urandom_range(0, 15));
        m.src_col = 4'($urandom_range(0, 15));
        m.command = nx_msg_pkg::nx_command_t'(2'($urandom_range(0, 2)));
        m.addr    = 4'($urandom);
        m.data    = 16'($urandom);
        if ((m.tgt_row == NODE_ROW) && (m.tgt_col == NODE_COL)) begin
            m.tgt_col = ~m.tgt_col;
        end
        if ((m.command == nx_msg_pkg::NX_CMD_RESPONSE) &&
            (m.src_row == NODE_ROW) && (m.src_col == NODE_COL)) begin
            m.src_col = ~m.src_col;
        end
        return m;
    endfunction

    // Model of what the node does with each accepted message
    task automatic predict_outcome(input nx_msg_pkg::nx_message_t m);
        nx_msg_pkg::nx_message_t resp;
        if ((m.tgt_row != NODE_ROW) || (m.tgt_col != NODE_COL)) begin
            fwd_mem[fwd_wr] <= m;
            fwd_wr          <= fwd_wr + 1'b1;
        end else begin
            case (m.command)
                nx_msg_pkg::NX_CMD_WRITE: shadow_regs[m.addr] = m.data;
                nx_msg_pkg::NX_CMD_READ: begin
                    // Reply goes back to the requester with the current value
                    resp = make_msg(m.src_row, m.src_col, NODE_ROW, NODE_COL,
                                    nx_msg_pkg::NX_CMD_RESPONSE, m.addr, shadow_regs[m.addr]);
                    resp_mem[resp_wr] <= resp;
                    resp_wr           <= resp_wr + 1'b1;
                end
                default: drops_expected <= drops_expected + 1;
            endcase
        end
    endtask

    // One push every two cycles, so in_full_o is current when sampled
    task automatic push_msg(input nx_msg_pkg::nx_message_t m);
        int unsigned waited;
        waited = 0;
        @(posedge clk_i);
        while (in_full_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timed out waiting for in_full_o to fall before a push");
            end
            @(posedge clk_i);
        end
        in_push_i <= 1'b1;
        in_msg_i  <= m;
        predict_outcome(m);
        @(posedge clk_i);
        in_push_i <= 1'b0;
    endtask

    // Every expected message delivered and the output empty
    task automatic wait_drained(input string what);
        int unsigned waited;
        waited = 0;
        @(negedge clk_i);
        while ((fwd_rd != fwd_wr) || (resp_rd != resp_wr) ||
               (drops_seen != drops_expected) || out_valid_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run($sformatf("timed out waiting for %s to drain", what));
            end
            @(negedge clk_i);
        end
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0)
            else report_mismatch(name, '0, {{(MSG_W-1){1'b0}}, value});
    endtask

    initial begin
        int unsigned pushes;
        logic        full_seen;
        int unsigned pick;
        void'($urandom(32'had42_310d));
        for (int i = 0; i < int'(REG_COUNT); i++) begin
            shadow_regs[i] = '0;
        end
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_low("out_valid_o", out_valid_o);
        check_low("dropped_o", dropped_o);
        check_low("in_full_o", in_full_o);

        // Every register reads zero after reset
        for (int a = 0; a < int'(REG_COUNT); a++) begin
            push_msg(make_msg(NODE_ROW, NODE_COL, 4'd1, 4'd0, nx_msg_pkg::NX_CMD_READ,
                              4'(a), 16'h0000));
        end
        wait_drained("reads after reset");

        // Pass-through traffic with random stall
        stall_random <= 1'b1;
        repeat (24) push_msg(random_forward());
        wait_drained("forwards under random stall");

        // Write each register, then read it back from varying sources
        for (int a = 0; a < int'(REG_COUNT); a++) begin
            push_msg(make_msg(NODE_ROW, NODE_COL, 4'd1, 4'd1, nx_msg_pkg::NX_CMD_WRITE,
                              4'(a), 16'($urandom)));
        end
        for (int a = 0; a < int'(REG_COUNT); a++) begin
            push_msg(make_msg(NODE_ROW, NODE_COL, 4'(a % 4), 4'd5, nx_msg_pkg::NX_CMD_READ,
                              4'(a), 16'h0000));
        end
        wait_drained("write and read back");

        // Stray responses for this node
        stall_random <= 1'b0;
        repeat (3) begin
            push_msg(make_msg(NODE_ROW, NODE_COL, 4'd7, 4'd1, nx_msg_pkg::NX_CMD_RESPONSE,
                              4'($urandom), 16'($urandom)));
        end
        wait_drained("stray responses");

        // One message held at the output while the FIFO fills behind it
        stall_hold <= 1'b1;
        repeat (2) @(posedge clk_i);
        pushes    = 0;
        full_seen = 1'b0;
        while (!full_seen) begin
            if (pushes > IN_DEPTH + 1) begin
                abort_run("in_full_o never rose while the output was stalled");
            end
            push_msg(random_forward());
            pushes++;
            @(negedge clk_i);
            full_seen = in_full_o;
        end
        assert (pushes == IN_DEPTH + 1)
            else report_mismatch("pushes until in_full_o", MSG_W'(IN_DEPTH + 1),
                                 MSG_W'(pushes));
        repeat (10) @(posedge clk_i);
        stall_hold <= 1'b0;
        wait_drained("release of back-pressure");

        // Mixed reads, writes and forwards with both egress sources competing
        stall_random <= 1'b1;
        repeat (40) begin
            pick = $urandom_range(0, 2);
            if (pick == 0) begin
                push_msg(make_msg(NODE_ROW, NODE_COL, 4'($urandom_range(4, 15)), 4'd2,
                                  nx_msg_pkg::NX_CMD_READ, 4'($urandom), 16'h0000));
            end else if (pick == 1) begin
                push_msg(make_msg(NODE_ROW, NODE_COL, 4'd9, 4'd9, nx_msg_pkg::NX_CMD_WRITE,
                                  4'($urandom), 16'($urandom)));
            end else begin
                push_msg(random_forward());
            end
        end
        wait_drained("interleaved traffic");

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* files.f */
rtl/nx_msg_pkg.sv
rtl/nx_node_pkg.sv
rtl/nx_fifo.sv
rtl/nx_msg_decoder.sv
rtl/nx_node_regs.sv
rtl/nx_egress_arb.sv
rtl/nx_node.sv
tb/tb_nx_node.sv

/* Makefile */
TOP := tb_nx_node

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
